// File: all.f
rtl/game_pkg.sv
rtl/game_regs.sv
rtl/vga_timing.sv
rtl/draw_cursor.sv
rtl/draw_gloves.sv
rtl/gloves_rom.sv
rtl/mouse_control.sv
rtl/pos_uart_tx.sv
rtl/goal_top.sv
verif/tb_goal_top.sv

// File: rtl/draw_cursor.sv
// crosshair overlay
// 11x11 cross centred on xpos, ypos, two register stages

`timescale 1ns/1ps

module draw_cursor (
    input  logic                  clk,
    input  logic                  rst,
    input  game_pkg::vga_stream_t in_stream,
    input  logic [11:0]           xpos,
    input  logic [11:0]           ypos,
    input  logic [11:0]           cursor_rgb,
    output game_pkg::vga_stream_t out_stream
);

    logic [12:0]           h_pos;
    logic [12:0]           v_pos;
    logic [12:0]           x_pos;
    logic [12:0]           y_pos;
    logic                  on_col;
    logic                  on_row;
    logic                  active;
    game_pkg::vga_stream_t s1_stream;
    logic                  s1_on;

    assign h_pos = {2'b00, in_stream.hcount};
    assign v_pos = {3'b000, in_stream.vcount};
    assign x_pos = {1'b0, xpos};
    assign y_pos = {1'b0, ypos};

    // widened so the +arm terms never wrap
    assign on_col = (h_pos == x_pos) && (v_pos + 13'(game_pkg::CURSOR_ARM) >= y_pos)
                    && (v_pos <= y_pos + 13'(game_pkg::CURSOR_ARM));
    assign on_row = (v_pos == y_pos) && (h_pos + 13'(game_pkg::CURSOR_ARM) >= x_pos)
                    && (h_pos <= x_pos + 13'(game_pkg::CURSOR_ARM));
    assign active = !in_stream.hblnk && !in_stream.vblnk;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_stream  <= '0;
            s1_on      <= 1'b0;
            out_stream <= '0;
        end else begin
            s1_stream  <= in_stream;
            s1_on      <= active && (on_col || on_row);
            out_stream <= s1_stream;
            if (s1_on) begin
                out_stream.rgb <= cursor_rgb;
            end
        end
    end

endmodule

// File: rtl/draw_gloves.sv
// glove sprite overlay
// 32x32 box at xpos, ypos, mask read from the sprite ROM, two register stages

`timescale 1ns/1ps

module draw_gloves (
    input  logic                  clk,
    input  logic                  rst,
    input  game_pkg::vga_stream_t in_stream,
    input  logic [11:0]           xpos,
    input  logic [11:0]           ypos,
    output logic [9:0]            pixel_addr,
    input  logic                  pixel_on,
    output game_pkg::vga_stream_t out_stream
);

    localparam logic [11:0] GLOVE_RGB = 12'hf80;

    logic [11:0]           col_off;
    logic [11:0]           row_off;
    logic                  in_cols;
    logic                  in_rows;
    logic                  active;
    game_pkg::vga_stream_t s1_stream;
    logic                  s1_in_box;

    assign col_off = {1'b0, in_stream.hcount} - xpos;
    assign row_off = {2'b00, in_stream.vcount} - ypos;

    // the >= terms catch offsets that wrapped around
    assign in_cols = ({1'b0, in_stream.hcount} >= xpos) && (col_off < game_pkg::GLOVE_SIZE);
    assign in_rows = ({2'b00, in_stream.vcount} >= ypos) && (row_off < game_pkg::GLOVE_SIZE);
    assign active  = !in_stream.hblnk && !in_stream.vblnk;

    assign pixel_addr = {row_off[4:0], col_off[4:0]};   // row major

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_stream  <= '0;
            s1_in_box  <= 1'b0;
            out_stream <= '0;
        end else begin
            s1_stream  <= in_stream;
            s1_in_box  <= active && in_cols && in_rows;
            out_stream <= s1_stream;
            if (s1_in_box && pixel_on) begin          // rom data lines up with stage 1
                out_stream.rgb <= GLOVE_RGB;
            end
        end
    end

endmodule

// File: rtl/game_pkg.sv
// game package
// raster timing, link constants and the shared stream, mode and position byte types

package game_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // 640x480 raster, 800x525 total
    localparam int H_ACTIVE     = 640;
    localparam int H_TOTAL      = 800;
    localparam int H_SYNC_START = 656;
    localparam int H_SYNC_END   = 752;
    localparam int V_ACTIVE     = 480;
    localparam int V_TOTAL      = 525;
    localparam int V_SYNC_START = 490;
    localparam int V_SYNC_END   = 492;

    ////////////////////////////////////////////////////////////////////////////
    // drawing and position link
    localparam int CLKS_PER_BIT = 434;         // 115200 baud at 50 MHz
    localparam int CURSOR_ARM   = 5;
    localparam int GLOVE_SIZE   = 32;

    localparam logic [2:0] TAG_X_LOW  = 3'b001;
    localparam logic [2:0] TAG_X_HIGH = 3'b010;

    localparam logic [1:0] REG_MODE       = 2'd0;
    localparam logic [1:0] REG_BG         = 2'd1;
    localparam logic [1:0] REG_CURSOR_RGB = 2'd2;

    typedef struct packed {
        logic [10:0] hcount;
        logic [9:0]  vcount;
        logic        hsync;
        logic        vsync;
        logic        hblnk;
        logic        vblnk;
        logic [11:0] rgb;
    } vga_stream_t;

    typedef enum logic [1:0] {
        SHOOTER = 2'd0,
        KEEPER  = 2'd1
    } game_mode_t;

    // one byte on the wire, seen raw or as payload over tag
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [4:0] payload;
            logic [2:0] tag;
        } field;
    } pos_byte_t;

endpackage

// File: rtl/game_regs.sv
// game configuration registers
// game mode, background colour and cursor colour, written by address strobe

`timescale 1ns/1ps

module game_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wr_en,
    input  logic [1:0]           reg_addr,
    input  logic [11:0]          reg_data,
    output game_pkg::game_mode_t mode,
    output logic [11:0]          bg_rgb,
    output logic [11:0]          cursor_rgb
);

    always_ff @(posedge clk) begin
        if (rst) begin
            mode       <= game_pkg::SHOOTER;
            bg_rgb     <= 12'h000;
            cursor_rgb <= 12'hfff;
        end else if (wr_en) begin
            case (reg_addr)
                game_pkg::REG_MODE: begin
                    mode <= reg_data[0] ? game_pkg::KEEPER : game_pkg::SHOOTER;
                end
                game_pkg::REG_BG:         bg_rgb     <= reg_data;
                game_pkg::REG_CURSOR_RGB: cursor_rgb <= reg_data;
                default: ;                               // unmapped, ignored
            endcase
        end
    end

endmodule

// File: rtl/gloves_rom.sv
// glove sprite ROM
// 32 rows of 32-bit masks, left and right glove side by side, one cycle read

`timescale 1ns/1ps

module gloves_rom (
    input  logic       clk,
    input  logic [9:0] pixel_addr,
    output logic       pixel_on
);

    // bit 31 is the leftmost column
    localparam logic [31:0] MASK [32] = '{
        32'h0000_0000, 32'h0000_0000, 32'h0db0_0db0, 32'h0db0_0db0,
        32'h1db8_1db8, 32'h1db8_1db8, 32'h1ff8_1ff8, 32'h1ff8_1ff8,
        32'h1ffe_1ffe, 32'h1ffe_1ffe, 32'h1ffe_1ffe, 32'h1ffc_1ffc,
        32'h1ff8_1ff8, 32'h1ff8_1ff8, 32'h1ff8_1ff8, 32'h0ff0_0ff0,
        32'h0ff0_0ff0, 32'h0ff0_0ff0, 32'h0ff0_0ff0, 32'h07e0_07e0,
        32'h07e0_07e0, 32'h0ff0_0ff0, 32'h0ff0_0ff0, 32'h0ff0_0ff0,
        32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000,
        32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000
    };

    always_ff @(posedge clk) begin
        pixel_on <= MASK[pixel_addr[9:5]][5'd31 - pixel_addr[4:0]];
    end

endmodule

// File: rtl/goal_top.sv
// penalty game overlay top
// registers, raster timing, cursor drawing and the position UART

`timescale 1ns/1ps

module goal_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [11:0]           xpos,
    input  logic [11:0]           ypos,
    input  logic                  wr_en,
    input  logic [1:0]            reg_addr,
    input  logic [11:0]           reg_data,
    output game_pkg::vga_stream_t out_stream,
    output logic                  uart_tx
);

    game_pkg::game_mode_t  mode;
    logic [11:0]           bg_rgb;
    logic [11:0]           cursor_rgb;
    game_pkg::vga_stream_t timing_stream;
    logic                  tx_load;
    logic [7:0]            tx_byte;
    logic                  tx_busy;

    game_regs u_game_regs (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (wr_en),
        .reg_addr   (reg_addr),
        .reg_data   (reg_data),
        .mode       (mode),
        .bg_rgb     (bg_rgb),
        .cursor_rgb (cursor_rgb)
    );

    vga_timing u_vga_timing (
        .clk    (clk),
        .rst    (rst),
        .bg_rgb (bg_rgb),
        .stream (timing_stream)
    );

    mouse_control u_mouse_control (
        .clk        (clk),
        .rst        (rst),
        .in_stream  (timing_stream),
        .xpos       (xpos),
        .ypos       (ypos),
        .mode       (mode),
        .cursor_rgb (cursor_rgb),
        .tx_busy    (tx_busy),
        .tx_load    (tx_load),
        .tx_byte    (tx_byte),
        .out_stream (out_stream)
    );

    pos_uart_tx u_pos_uart_tx (
        .clk     (clk),
        .rst     (rst),
        .tx_load (tx_load),
        .tx_byte (tx_byte),
        .tx_busy (tx_busy),
        .uart_tx (uart_tx)
    );

endmodule

// File: rtl/mouse_control.sv
// cursor selection and position link
// picks the crosshair or glove stream by game mode and sends the
// cursor x position as two tagged bytes once per frame

`timescale 1ns/1ps

module mouse_control (
    input  logic                  clk,
    input  logic                  rst,
    input  game_pkg::vga_stream_t in_stream,
    input  logic [11:0]           xpos,
    input  logic [11:0]           ypos,
    input  game_pkg::game_mode_t  mode,
    input  logic [11:0]           cursor_rgb,
    input  logic                  tx_busy,
    output logic                  tx_load,
    output logic [7:0]            tx_byte,
    output game_pkg::vga_stream_t out_stream
);

    typedef enum logic [1:0] {
        IDLE,
        SEND_LOW,
        SEND_HIGH
    } send_state_t;

    game_pkg::vga_stream_t cursor_stream;
    game_pkg::vga_stream_t gloves_stream;
    game_pkg::vga_stream_t sel_stream;
    logic [9:0]            gloves_addr;
    logic                  gloves_on;
    send_state_t           state;
    logic [9:0]            x_lat;
    logic                  frame_mark;
    game_pkg::pos_byte_t   low_byte;
    game_pkg::pos_byte_t   high_byte;

    draw_cursor u_draw_cursor (
        .clk        (clk),
        .rst        (rst),
        .in_stream  (in_stream),
        .xpos       (xpos),
        .ypos       (ypos),
        .cursor_rgb (cursor_rgb),
        .out_stream (cursor_stream)
    );

    draw_gloves u_draw_gloves (
        .clk        (clk),
        .rst        (rst),
        .in_stream  (in_stream),
        .xpos       (xpos),
        .ypos       (ypos),
        .pixel_addr (gloves_addr),
        .pixel_on   (gloves_on),
        .out_stream (gloves_stream)
    );

    gloves_rom u_gloves_rom (
        .clk        (clk),
        .pixel_addr (gloves_addr),
        .pixel_on   (gloves_on)
    );

    ////////////////////////////////////////////////////////////////////////////
    // stream select and output register

    assign sel_stream = (mode == game_pkg::KEEPER) ? gloves_stream : cursor_stream;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_stream <= '0;
        end else begin
            out_stream <= sel_stream;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // per-frame send of x position

    assign frame_mark = (out_stream.hcount == 11'd0)
                        && (out_stream.vcount == 10'(game_pkg::V_ACTIVE));   // vblank start

    always_comb begin
        low_byte.field.tag      = game_pkg::TAG_X_LOW;
        low_byte.field.payload  = x_lat[4:0];
        high_byte.field.tag     = game_pkg::TAG_X_HIGH;
        high_byte.field.payload = x_lat[9:5];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            tx_load <= 1'b0;
        end else begin
            tx_load <= 1'b0;
            case (state)
                IDLE: begin
                    if (frame_mark) begin
                        state <= SEND_LOW;
                    end
                end
                SEND_LOW: begin
                    if (!tx_busy) begin
                        tx_load <= 1'b1;
                        state   <= SEND_HIGH;
                    end
                end
                SEND_HIGH: begin
                    if (!tx_busy && !tx_load) begin     // busy lags load by a cycle
                        tx_load <= 1'b1;
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && frame_mark) begin
            x_lat <= xpos[9:0];
        end
        if (state == SEND_LOW) begin
            tx_byte <= low_byte.raw;
        end else if (state == SEND_HIGH) begin
            tx_byte <= high_byte.raw;
        end
    end

    a_load_not_busy: assert property (@(posedge clk) disable iff (rst)
        tx_load |-> !tx_busy);

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {IDLE, SEND_LOW, SEND_HIGH});

endmodule

// File: rtl/pos_uart_tx.sv
// 8N1 UART transmitter
// loads one byte on a strobe, shifts out start, 8 data bits LSB first and stop

`timescale 1ns/1ps

module pos_uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_load,
    input  logic [7:0] tx_byte,
    output logic       tx_busy,
    output logic       uart_tx
);

    logic [8:0] bit_timer;
    logic [3:0] bit_idx;
    logic [9:0] frame;
    logic       bit_end;

    assign bit_end = (bit_timer == 9'(game_pkg::CLKS_PER_BIT - 1));
    assign uart_tx = frame[0];                  // all ones when idle

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_busy   <= 1'b0;
            bit_timer <= '0;
            bit_idx   <= '0;
            frame     <= '1;
        end else if (!tx_busy) begin
            if (tx_load) begin
                tx_busy   <= 1'b1;
                bit_timer <= '0;
                bit_idx   <= '0;
                frame     <= {1'b1, tx_byte, 1'b0};
            end
        end else if (bit_end) begin
            bit_timer <= '0;
            frame     <= {1'b1, frame[9:1]};     // refill with idle level
            if (bit_idx == 4'd9) begin
                tx_busy <= 1'b0;                 // end of stop bit
                bit_idx <= '0;
            end else begin
                bit_idx <= bit_idx + 4'd1;
            end
        end else begin
            bit_timer <= bit_timer + 9'd1;
        end
    end

    a_idle_high: assert property (@(posedge clk) disable iff (rst)
        !tx_busy |-> uart_tx);

endmodule

// File: rtl/vga_timing.sv
// VGA timing generator
// pixel and line counters with registered sync, blanking and background colour

`timescale 1ns/1ps

module vga_timing (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [11:0]           bg_rgb,
    output game_pkg::vga_stream_t stream
);

    logic [10:0] h_cnt;
    logic [9:0]  v_cnt;
    logic        h_act;
    logic        v_act;

    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == 11'(game_pkg::H_TOTAL - 1)) begin
            h_cnt <= '0;
            if (v_cnt == 10'(game_pkg::V_TOTAL - 1)) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 10'd1;
            end
        end else begin
            h_cnt <= h_cnt + 11'd1;
        end
    end

    assign h_act = (h_cnt < game_pkg::H_ACTIVE);
    assign v_act = (v_cnt < game_pkg::V_ACTIVE);

    always_ff @(posedge clk) begin
        if (rst) begin
            stream <= '0;
        end else begin
            stream.hcount <= h_cnt;
            stream.vcount <= v_cnt;
            stream.hsync  <= (h_cnt >= game_pkg::H_SYNC_START) && (h_cnt < game_pkg::H_SYNC_END);
            stream.vsync  <= (v_cnt >= game_pkg::V_SYNC_START) && (v_cnt < game_pkg::V_SYNC_END);
            stream.hblnk  <= !h_act;
            stream.vblnk  <= !v_act;
            stream.rgb    <= (h_act && v_act) ? bg_rgb : 12'h000;   // black in blanking
        end
    end

    a_hcount_range: assert property (@(posedge clk) disable iff (rst)
        stream.hcount < game_pkg::H_TOTAL);

endmodule

// File: verif/tb_goal_top.sv
// testbench for the penalty game overlay
// random cursor positions, register writes, UART decoding and assertion checks

`timescale 1ns/1ps

module tb_goal_top;

    localparam int          FRAME_CYCLES   = game_pkg::H_TOTAL * game_pkg::V_TOTAL;
    localparam int          TIMEOUT_CYCLES = 5 * FRAME_CYCLES;     // four frames plus one spare
    localparam int          HALF_BIT       = game_pkg::CLKS_PER_BIT / 2;
    localparam logic [11:0] GLOVE_RGB      = 12'hf80;
    localparam logic [11:0] CURSOR_RGB     = 12'hfff;

    logic                  clk;
    logic                  rst;
    logic [11:0]           xpos;
    logic [11:0]           ypos;
    logic                  wr_en;
    logic [1:0]            reg_addr;
    logic [11:0]           reg_data;
    game_pkg::vga_stream_t out_stream;
    logic                  uart_tx;

    logic [31:0]           lfsr;
    game_pkg::game_mode_t  exp_mode;
    logic [11:0]           exp_bg;
    logic                  pix_en;
    int                    cycle_cnt = 0;
    int                    glove_px;
    int                    cross_px;
    logic                  px_act;
    logic                  px_cross;
    logic                  px_box;
    logic [11:0]           shooter_rgb;
    logic                  exp_hsync;
    logic                  exp_vsync;
    logic                  exp_hblnk;
    logic                  exp_vblnk;
    logic                  frame_mark;
    logic [10:0]           next_h;
    logic [9:0]            next_v;
    logic [10:0]           step_h;
    logic [9:0]            step_v;

    logic                  rx_busy;
    logic                  rx_prev;
    int                    rx_cnt;
    int                    rx_bit;
    logic [7:0]            rx_shift;
    logic                  rx_start_ok;
    logic                  rx_stop;
    logic                  rx_done;
    game_pkg::pos_byte_t   rx_pos;
    logic                  rx_expected;
    logic [2:0]            rx_exp_tag;
    logic [4:0]            rx_exp_payload;
    logic [2:0]            exp_tag [0:15];
    logic [4:0]            exp_payload [0:15];
    int                    wr_ptr;
    int                    rd_ptr;

    goal_top DUT (
        .clk        (clk),
        .rst        (rst),
        .xpos       (xpos),
        .ypos       (ypos),
        .wr_en      (wr_en),
        .reg_addr   (reg_addr),
        .reg_data   (reg_data),
        .out_stream (out_stream),
        .uart_tx    (uart_tx)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // helpers

    task automatic end_with_failure();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] %s expected %0h got %0h", name, expected, actual);
        end_with_failure();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        end_with_failure();
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'hd000_0001) : (lfsr >> 1);
        end
        return value;
    endfunction

    function automatic bit on_crosshair(input int h, input int v, input int x, input int y);
        return ((h == x) && (v >= y - game_pkg::CURSOR_ARM) && (v <= y + game_pkg::CURSOR_ARM))
            || ((v == y) && (h >= x - game_pkg::CURSOR_ARM) && (h <= x + game_pkg::CURSOR_ARM));
    endfunction

    function automatic bit in_glove_box(input int h, input int v, input int x, input int y);
        return (h >= x) && (h < x + game_pkg::GLOVE_SIZE)
            && (v >= y) && (v < y + game_pkg::GLOVE_SIZE);
    endfunction

    task automatic write_reg(input logic [1:0] addr, input logic [11:0] data);
        wr_en    = 1'b1;
        reg_addr = addr;
        reg_data = data;
        @(posedge clk);
        #2;
        wr_en    = 1'b0;
    endtask

    task automatic new_position();
        xpos = 12'(take_bits(10) % 601);                 // keeps cursor and glove on screen
        ypos = 12'(take_bits(9) % 441);
    endtask

    task automatic wait_out_line(input int line);
        do begin
            @(posedge clk);
            #2;
        end while (!((out_stream.vcount == line) && (out_stream.hcount == 0)));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference values for the current output pixel

    always_comb begin
        px_act      = !out_stream.hblnk && !out_stream.vblnk;
        px_cross    = on_crosshair(out_stream.hcount, out_stream.vcount, xpos, ypos);
        px_box      = in_glove_box(out_stream.hcount, out_stream.vcount, xpos, ypos);
        shooter_rgb = px_cross ? CURSOR_RGB : exp_bg;
        exp_hsync   = (out_stream.hcount >= game_pkg::H_SYNC_START)
                      && (out_stream.hcount < game_pkg::H_SYNC_END);
        exp_vsync   = (out_stream.vcount >= game_pkg::V_SYNC_START)
                      && (out_stream.vcount < game_pkg::V_SYNC_END);
        exp_hblnk   = (out_stream.hcount >= game_pkg::H_ACTIVE);
        exp_vblnk   = (out_stream.vcount >= game_pkg::V_ACTIVE);
        frame_mark  = (out_stream.hcount == 0) && (out_stream.vcount == game_pkg::V_ACTIVE);
        next_h      = (out_stream.hcount == game_pkg::H_TOTAL - 1) ? 11'd0
                      : out_stream.hcount + 11'd1;
        next_v      = out_stream.vcount;
        if (out_stream.hcount == game_pkg::H_TOTAL - 1) begin
            next_v = (out_stream.vcount == game_pkg::V_TOTAL - 1) ? 10'd0
                     : out_stream.vcount + 10'd1;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            pix_en   <= 1'b0;
            glove_px <= 0;
            cross_px <= 0;
        end else begin
            step_h <= next_h;
            step_v <= next_v;
            if (out_stream.hcount == 11'd1) begin
                pix_en <= 1'b1;                          // first pixel predates the bg write
            end
            if (pix_en && px_act && exp_mode == game_pkg::KEEPER && px_box
                && out_stream.rgb == GLOVE_RGB) begin
                glove_px <= glove_px + 1;
            end
            if (pix_en && px_act && exp_mode == game_pkg::SHOOTER && px_cross) begin
                cross_px <= cross_px + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_problem("timeout, the run did not finish within five frame lengths");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // expected position bytes and UART receiver model

    always @(posedge clk) begin
        if (rst) begin
            wr_ptr <= 0;
        end else if (frame_mark) begin
            exp_tag[wr_ptr]         <= game_pkg::TAG_X_LOW;
            exp_payload[wr_ptr]     <= xpos[4:0];
            exp_tag[wr_ptr + 1]     <= game_pkg::TAG_X_HIGH;
            exp_payload[wr_ptr + 1] <= xpos[9:5];
            wr_ptr                  <= wr_ptr + 2;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            rx_busy     <= 1'b0;
            rx_prev     <= 1'b1;
            rx_cnt      <= 0;
            rx_bit      <= 0;
            rx_done     <= 1'b0;
            rx_start_ok <= 1'b0;
            rx_stop     <= 1'b0;
            rx_expected <= 1'b0;
            rd_ptr      <= 0;
        end else begin
            rx_prev <= uart_tx;
            rx_done <= 1'b0;
            if (!rx_busy) begin
                if (rx_prev && !uart_tx) begin           // falling start edge
                    rx_busy <= 1'b1;
                    rx_cnt  <= HALF_BIT - 1;
                    rx_bit  <= 0;
                end
            end else if (rx_cnt != 0) begin
                rx_cnt <= rx_cnt - 1;
            end else begin
                rx_cnt <= game_pkg::CLKS_PER_BIT - 1;
                rx_bit <= rx_bit + 1;
                if (rx_bit == 0) begin
                    rx_start_ok <= !uart_tx;
                end else if (rx_bit < 9) begin
                    rx_shift <= {uart_tx, rx_shift[7:1]};   // lsb first
                end else begin
                    rx_busy        <= 1'b0;
                    rx_stop        <= uart_tx;
                    rx_done        <= 1'b1;
                    rx_pos.raw     <= rx_shift;
                    rx_expected    <= (rd_ptr < wr_ptr);
                    rx_exp_tag     <= exp_tag[rd_ptr];
                    rx_exp_payload <= exp_payload[rd_ptr];
                    rd_ptr         <= rd_ptr + 1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks

    a_reset_state: assert property (@(posedge clk) rst |=> (out_stream == '0) && uart_tx)
        else report_problem("out_stream or uart_tx not at its reset value during reset");
    // raster counters step by one and wrap at the totals
    a_hcount_step: assert property (@(posedge clk) disable iff (rst)
        pix_en |-> out_stream.hcount == step_h)
        else report_mismatch("out_stream.hcount", $sampled(step_h), $sampled(out_stream.hcount));
    a_vcount_step: assert property (@(posedge clk) disable iff (rst)
        pix_en |-> out_stream.vcount == step_v)
        else report_mismatch("out_stream.vcount", $sampled(step_v), $sampled(out_stream.vcount));
    a_hsync: assert property (@(posedge clk) disable iff (rst) out_stream.hsync == exp_hsync)
        else report_mismatch("out_stream.hsync", $sampled(exp_hsync), $sampled(out_stream.hsync));
    a_vsync: assert property (@(posedge clk) disable iff (rst) out_stream.vsync == exp_vsync)
        else report_mismatch("out_stream.vsync", $sampled(exp_vsync), $sampled(out_stream.vsync));
    a_hblnk: assert property (@(posedge clk) disable iff (rst) out_stream.hblnk == exp_hblnk)
        else report_mismatch("out_stream.hblnk", $sampled(exp_hblnk), $sampled(out_stream.hblnk));
    a_vblnk: assert property (@(posedge clk) disable iff (rst) out_stream.vblnk == exp_vblnk)
        else report_mismatch("out_stream.vblnk", $sampled(exp_vblnk), $sampled(out_stream.vblnk));
    a_blank_black: assert property (@(posedge clk) disable iff (rst)
        !px_act |-> out_stream.rgb == 12'h000)
        else report_mismatch("out_stream.rgb", 0, $sampled(out_stream.rgb));
    a_shooter_rgb: assert property (@(posedge clk) disable iff (rst)
        (pix_en && px_act && exp_mode == game_pkg::SHOOTER) |-> out_stream.rgb == shooter_rgb)
        else report_mismatch("out_stream.rgb", $sampled(shooter_rgb), $sampled(out_stream.rgb));
    a_keeper_outside: assert property (@(posedge clk) disable iff (rst)
        (pix_en && px_act && exp_mode == game_pkg::KEEPER && !px_box) |-> out_stream.rgb == exp_bg)
        else report_mismatch("out_stream.rgb", $sampled(exp_bg), $sampled(out_stream.rgb));
    a_keeper_inside: assert property (@(posedge clk) disable iff (rst)
        (pix_en && px_act && exp_mode == game_pkg::KEEPER && px_box)
        |-> (out_stream.rgb == exp_bg) || (out_stream.rgb == GLOVE_RGB))
        else report_mismatch("out_stream.rgb", GLOVE_RGB, $sampled(out_stream.rgb));
    a_bytes_drained: assert property (@(posedge clk) disable iff (rst)
        frame_mark |-> rd_ptr == wr_ptr)
        else report_problem("position bytes of the previous frame never arrived");
    a_rx_framing: assert property (@(posedge clk) disable iff (rst)
        rx_done |-> rx_start_ok && rx_stop)
        else report_problem("UART byte arrived with a bad start or stop bit");
    a_rx_expected: assert property (@(posedge clk) disable iff (rst) rx_done |-> rx_expected)
        else report_problem("UART byte arrived that no frame asked for");
    a_rx_tag: assert property (@(posedge clk) disable iff (rst)
        rx_done |-> rx_pos.field.tag == rx_exp_tag)
        else report_mismatch("uart tag", $sampled(rx_exp_tag), $sampled(rx_pos.field.tag));
    a_rx_payload: assert property (@(posedge clk) disable iff (rst)
        rx_done |-> rx_pos.field.payload == rx_exp_payload)
        else report_mismatch("uart payload", $sampled(rx_exp_payload),
                             $sampled(rx_pos.field.payload));

    ////////////////////////////////////////////////////////////////////////////
    // stimulus: two shooter frames, then two keeper frames

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        wr_en    = 1'b0;
        reg_addr = '0;
        reg_data = '0;
        lfsr     = 32'h2491b7d8;
        exp_mode = game_pkg::SHOOTER;
        exp_bg   = 12'h000;
        new_position();
        repeat (5) @(posedge clk);
        #2;
        rst    = 1'b0;
        exp_bg = 12'h036;
        write_reg(game_pkg::REG_BG, 12'h036);
        wait_out_line(500);                              // vblank of frame 0
        new_position();
        wait_out_line(500);
        exp_mode = game_pkg::KEEPER;
        exp_bg   = 12'h0c4;
        write_reg(game_pkg::REG_MODE, 12'h001);
        write_reg(game_pkg::REG_BG, 12'h0c4);
        new_position();
        wait_out_line(500);
        new_position();
        wait_out_line(500);                              // last frame's bytes are in by now
        if (wr_ptr == 8 && rd_ptr == wr_ptr && glove_px > 0 && cross_px > 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            report_problem("run ended with position bytes missing or no cursor or glove drawn");
        end
    end

endmodule
